/* Bender.yml */
package:
  name: jtag_uart

sources:
  - include_dirs:
      - hw
    files:
      - hw/jtag_uart_pkg.sv
      - hw/tap_if.sv
      - hw/tap_controller.sv
      - hw/rv_mini_core.sv
      - hw/jtag_tx_buffer.sv
      - hw/jtag_uart_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/jtag_uart_checker.sv
      - tests/jtag_uart_tb.sv

/* hw/jtag_tx_buffer.sv */
// ==========================================================
// JTAG UART transmit buffer
// Circular byte queue filled from the core
// USER1 data register with capture, shift and tdo
// Bypass bit for any other instruction
// ==========================================================

`timescale 1ns/1ps
`include "jtag_uart_config.svh"

module jtag_tx_buffer (
    input  logic       tck,
    input  logic       reset_n,
    input  logic       wr_valid,
    input  logic [7:0] wr_data,
    output logic       credit_ret,
    tap_if.dr          tap,
    output logic       tdo
);

    localparam int PTR_W = $clog2(`JTAG_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`JTAG_FIFO_DEPTH + 1);

    logic [7:0]         queue [`JTAG_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [7:0]         user1_dr;
    logic               bypass;
    logic               empty;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`JTAG_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign pop   = tap.update_dr && tap.user1_sel && !empty;   // Host consumed the head

    // ======================== Byte queue ========================
    always_ff @(posedge tck) begin
        if (wr_valid) begin
            queue[wr_ptr] <= wr_data;           // Credits guarantee a free slot
        end
    end

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (wr_valid) wr_ptr <= ptr_inc(wr_ptr);
            if (pop)      rd_ptr <= ptr_inc(rd_ptr);
            count      <= count + CNT_W'(wr_valid) - CNT_W'(pop);
            credit_ret <= pop;                  // One pulse per popped byte
        end
    end

    // ======================== Data registers ========================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            user1_dr <= '0;
            bypass   <= 1'b0;
        end else if (tap.capture_dr) begin
            bypass <= 1'b0;
            if (tap.user1_sel) user1_dr <= empty ? 8'h00 : queue[rd_ptr];
        end else if (tap.shift_dr) begin
            bypass <= tap.tdi_bit;
            if (tap.user1_sel) user1_dr <= {1'b0, user1_dr[7:1]};  // LSB out first
        end
    end

    assign tdo = tap.user1_sel ? user1_dr[0] : bypass;

endmodule

/* hw/jtag_uart_config.svh */
// ==========================================================
// Build-time sizes for the JTAG UART debug subsystem
// Transmit queue depth, JTAG IR length and USER1 code
// Store address bit that maps a store onto the UART
// ==========================================================

`ifndef JTAG_UART_CONFIG_SVH
`define JTAG_UART_CONFIG_SVH

`define JTAG_FIFO_DEPTH     16                      // Byte entries, also the core's start credit
`define JTAG_IR_WIDTH       10                      // Instruction register length
`define JTAG_USER1          (`JTAG_IR_WIDTH'(1))    // Selects the UART data register

// Any store with this address bit set goes to the UART
`define JTAG_UART_ADDR_BIT  31

`endif

/* hw/jtag_uart_pkg.sv */
// ==========================================================
// Shared types for the JTAG UART debug subsystem
// TAP state encoding, RV32 S/I field layouts, opcodes
// ==========================================================

package jtag_uart_pkg;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        TEST_LOGIC_RESET = 4'h0,
        RUN_TEST_IDLE    = 4'h1,
        SELECT_DR_SCAN   = 4'h2,
        CAPTURE_DR       = 4'h3,
        SHIFT_DR         = 4'h4,
        EXIT1_DR         = 4'h5,
        PAUSE_DR         = 4'h6,
        EXIT2_DR         = 4'h7,
        UPDATE_DR        = 4'h8,
        SELECT_IR_SCAN   = 4'h9,
        CAPTURE_IR       = 4'ha,
        SHIFT_IR         = 4'hb,
        EXIT1_IR         = 4'hc,
        PAUSE_IR         = 4'hd,
        EXIT2_IR         = 4'he,
        UPDATE_IR        = 4'hf
    } tap_state_e;

    typedef struct packed {
        logic [6:0] imm_hi;     // imm[11:5]
        logic [4:0] rs2;        // Store data source
        logic [4:0] rs1;        // Base address
        logic [2:0] funct3;
        logic [4:0] imm_lo;     // imm[4:0]
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Same word, two field views
    typedef union packed {
        s_type_t s;
        i_type_t i;
    } instr_u;

    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

endpackage

/* hw/jtag_uart_top.sv */
// ==========================================================
// JTAG UART debug subsystem top level
// Core, TAP controller and transmit buffer on one tck
// ==========================================================

`timescale 1ns/1ps

module jtag_uart_top (
    input  logic        tck,
    input  logic        reset_n,
    input  logic        tms,
    input  logic        tdi,
    output logic        tdo,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    output logic        instr_ready,
    output logic [31:0] a0
);

    logic       wr_valid;
    logic [7:0] wr_data;
    logic       credit_ret;

    tap_if tap_bus ();

    tap_controller tap_controller_inst (
        .tck     (tck),
        .reset_n (reset_n),
        .tms     (tms),
        .tdi     (tdi),
        .tap     (tap_bus.ctrl)
    );

    rv_mini_core rv_mini_core_inst (
        .tck         (tck),
        .reset_n     (reset_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .wr_valid    (wr_valid),
        .wr_data     (wr_data),
        .credit_ret  (credit_ret),
        .a0          (a0)
    );

    jtag_tx_buffer jtag_tx_buffer_inst (
        .tck        (tck),
        .reset_n    (reset_n),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .credit_ret (credit_ret),
        .tap        (tap_bus.dr),
        .tdo        (tdo)
    );

endmodule

/* hw/rv_mini_core.sv */
// ==========================================================
// Minimal RV32 execute core
// 32-entry register file, x0 hard zero
// ADDI and SW from a valid/ready instruction port
// UART store decode and transmit credit counter
// ==========================================================

`timescale 1ns/1ps
`include "jtag_uart_config.svh"

module rv_mini_core import jtag_uart_pkg::*; (
    input  logic        tck,
    input  logic        reset_n,
    input  logic [31:0] instr,
    input  logic        instr_valid,
    output logic        instr_ready,
    output logic        wr_valid,
    output logic [7:0]  wr_data,
    input  logic        credit_ret,
    output logic [31:0] a0
);

    localparam int CRED_W = $clog2(`JTAG_FIFO_DEPTH + 1);

    logic [31:0]        regs [32];
    logic [CRED_W-1:0]  credits;        // Free queue slots as seen by the core
    instr_u             word;
    logic               accept;
    logic               is_addi;
    logic               is_store;
    logic               uart_store;
    logic [31:0]        i_imm;
    logic [31:0]        s_imm;
    logic [31:0]        st_addr;

    // ======================== Decode ========================
    assign word     = instr;
    assign accept   = instr_valid && instr_ready;
    assign is_addi  = (word.i.opcode == OPC_OP_IMM);
    assign is_store = (word.s.opcode == OPC_STORE);

    assign i_imm = {{20{word.i.imm[11]}}, word.i.imm};
    assign s_imm = {{20{word.s.imm_hi[6]}}, word.s.imm_hi, word.s.imm_lo};

    assign st_addr    = regs[word.s.rs1] + s_imm;
    assign uart_store = accept && is_store && st_addr[`JTAG_UART_ADDR_BIT];  // Other stores dropped

    // No credit means no issue of anything, keeps program order
    assign instr_ready = (credits != '0);
    assign a0          = regs[10];

    // ======================== Register file ========================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (accept && is_addi && (word.i.rd != 5'd0)) begin
            regs[word.i.rd] <= regs[word.i.rs1] + i_imm;    // x0 never written
        end
    end

    // ======================== Write channel ========================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= uart_store;                 // One cycle per store
        end
    end

    always_ff @(posedge tck) begin
        if (uart_store) begin
            wr_data <= regs[word.s.rs2][7:0];       // Low byte only
        end
    end

    // Spend on issue, regain on return, both at once cancel
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            credits <= CRED_W'(`JTAG_FIFO_DEPTH);
        end else begin
            case ({uart_store, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

/* hw/tap_controller.sv */
// ==========================================================
// JTAG TAP controller
// 16-state FSM stepped by tms on every tck edge
// Instruction register with capture and shift
// DR strobe and USER1 decode onto tap_if
// ==========================================================

`timescale 1ns/1ps
`include "jtag_uart_config.svh"

module tap_controller import jtag_uart_pkg::*; (
    input  logic tck,
    input  logic reset_n,
    input  logic tms,
    input  logic tdi,
    tap_if.ctrl  tap
);

    tap_state_e                 state;
    tap_state_e                 state_nxt;
    logic [`JTAG_IR_WIDTH-1:0]  ir;

    // ======================== State graph ========================
    always_comb begin
        case (state)
            TEST_LOGIC_RESET: state_nxt = tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_nxt = tms ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_nxt = tms ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_nxt = tms ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_nxt = tms ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_nxt = tms ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_nxt = tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_nxt = tms ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_nxt = tms ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_nxt = tms ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_nxt = tms ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_nxt = tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
        endcase
    end

    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            state <= TEST_LOGIC_RESET;
        end else begin
            state <= state_nxt;
        end
    end

    // ======================== Instruction register ========================
    always_ff @(posedge tck or negedge reset_n) begin
        if (!reset_n) begin
            ir <= '0;
        end else if (state == CAPTURE_IR) begin
            ir <= `JTAG_USER1;                          // Fixed capture pattern
        end else if (state == SHIFT_IR) begin
            ir <= {tdi, ir[`JTAG_IR_WIDTH-1:1]};        // New bit enters at MSB
        end
    end

    // Strobes are pure state decode, valid for the edge that ends the state
    assign tap.capture_dr = (state == CAPTURE_DR);
    assign tap.shift_dr   = (state == SHIFT_DR);
    assign tap.update_dr  = (state == UPDATE_DR);
    assign tap.user1_sel  = (ir == `JTAG_USER1);
    assign tap.tdi_bit    = tdi;

endmodule

/* hw/tap_if.sv */
// ==========================================================
// TAP decode strobes from controller to data register
// ==========================================================

`timescale 1ns/1ps

interface tap_if;

    logic capture_dr;   // In Capture-DR
    logic shift_dr;     // In Shift-DR
    logic update_dr;    // In Update-DR
    logic user1_sel;    // IR holds USER1
    logic tdi_bit;      // Raw tdi

    // Controller side
    modport ctrl (
        output capture_dr, shift_dr, update_dr, user1_sel, tdi_bit
    );

    // Data register side
    modport dr (
        input capture_dr, shift_dr, update_dr, user1_sel, tdi_bit
    );

endinterface

/* jtag_uart.f */
+incdir+hw
hw/jtag_uart_pkg.sv
hw/tap_if.sv
hw/tap_controller.sv
hw/rv_mini_core.sv
hw/jtag_tx_buffer.sv
hw/jtag_uart_top.sv
tests/jtag_uart_checker.sv
tests/jtag_uart_tb.sv

/* tests/jtag_uart_checker.sv */
// ==========================================================
// Concurrent assertions on the JTAG UART top-level ports
// tdo known, ready after reset, a0 stable when idle
// Bound into jtag_uart_top
// ==========================================================

`timescale 1ns/1ps

module jtag_uart_checker (
    input logic        tck,
    input logic        reset_n,
    input logic        tdo,
    input logic        instr_valid,
    input logic        instr_ready,
    input logic [31:0] a0
);

    int assert_fails = 0;   // Failed assertion count

    // Data register and bypass bit are both reset
    tdo_known: assert property (@(posedge tck) disable iff (!reset_n) !$isunknown(tdo))
        else begin
            assert_fails++;
            $error("tdo is unknown after reset");
        end

    // Full credit count right out of reset
    ready_after_reset: assert property (@(posedge tck) $rose(reset_n) |-> instr_ready)
        else begin
            assert_fails++;
            $error("instr_ready is low in the cycle after reset release");
        end

    // No accepted word in the last two cycles, so no register write
    a0_stable_idle: assert property (@(posedge tck) disable iff (!reset_n)
        ($past(!instr_valid) && $past(!instr_valid, 2)) |-> $stable(a0))
        else begin
            assert_fails++;
            $error("a0 changed while instr_valid was low");
        end

endmodule

bind jtag_uart_top jtag_uart_checker jtag_uart_checker_inst (.*);

/* tests/jtag_uart_tb.sv */
// ==========================================================
// Testbench for the JTAG UART debug subsystem
// Clock, reset, instruction and JTAG driver tasks
// Directed tests: reset, ADDI, UART stores, ignored stores,
// credit back-pressure
// ==========================================================

`timescale 1ns/1ps
`include "jtag_uart_config.svh"

module jtag_uart_tb;

    localparam int TIMEOUT_CYCLES = 64;                     // Max wait for instr_ready
    localparam int HOLD_CYCLES    = 20;                     // Back-pressure window
    localparam int NUM_BP         = `JTAG_FIFO_DEPTH + 1;   // One store past the credits

    logic        tck;
    logic        reset_n;
    logic        tms;
    logic        tdi;
    logic        tdo;
    logic [31:0] instr;
    logic        instr_valid;
    logic        instr_ready;
    logic [31:0] a0;
    integer      seed;

    jtag_uart_top jtag_uart_top_inst (
        .tck         (tck),
        .reset_n     (reset_n),
        .tms         (tms),
        .tdi         (tdi),
        .tdo         (tdo),
        .instr       (instr),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .a0          (a0)
    );

    initial begin
        tck = 1'b0;
        forever #50 tck = ~tck;                 // 100 ns period
    end

    // ======================== RV32 encoders ========================
    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // ======================== Checks and drivers ========================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Error: timed out waiting for instr_ready during %s", what);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    endtask

    task automatic send_instr(input logic [31:0] word);
        int cycles;
        cycles = 0;
        @(negedge tck);
        instr       = word;
        instr_valid = 1'b1;
        while (!instr_ready) begin              // Ready only moves on posedge
            if (cycles == TIMEOUT_CYCLES) report_timeout("send_instr");
            @(negedge tck);
            cycles++;
        end
        @(posedge tck);                         // Accept edge
        @(negedge tck);
        instr_valid = 1'b0;
    endtask

    // One TAP step, tdo sampled before the edge
    task automatic jtag_step(input logic tms_val, input logic tdi_val, output logic tdo_val);
        @(negedge tck);
        tdo_val = tdo;
        tms     = tms_val;
        tdi     = tdi_val;
        @(posedge tck);
    endtask

    task automatic jtag_reset();
        logic unused;
        repeat (5) jtag_step(1'b1, 1'b0, unused);   // Test-Logic-Reset from anywhere
        jtag_step(1'b0, 1'b0, unused);              // Run-Test-Idle
    endtask

    task automatic jtag_load_ir(input logic [`JTAG_IR_WIDTH-1:0] code);
        logic unused;
        jtag_step(1'b1, 1'b0, unused);          // Select-DR
        jtag_step(1'b1, 1'b0, unused);          // Select-IR
        jtag_step(1'b0, 1'b0, unused);          // Capture-IR
        jtag_step(1'b0, 1'b0, unused);          // Shift-IR
        for (int i = 0; i < `JTAG_IR_WIDTH; i++) begin
            jtag_step(i == `JTAG_IR_WIDTH - 1, code[i], unused);  // LSB first
        end
        jtag_step(1'b1, 1'b0, unused);          // Update-IR
        jtag_step(1'b0, 1'b0, unused);          // Run-Test-Idle
    endtask

    task automatic jtag_read_byte(output logic [7:0] data);
        logic unused;
        jtag_step(1'b1, 1'b0, unused);          // Select-DR
        jtag_step(1'b0, 1'b0, unused);          // Capture-DR
        jtag_step(1'b0, 1'b0, unused);          // Capture edge, into Shift-DR
        for (int i = 0; i < 8; i++) begin
            jtag_step(i == 7, 1'b0, data[i]);   // Last shift exits to Exit1-DR
        end
        jtag_step(1'b1, 1'b0, unused);          // Update-DR
        jtag_step(1'b0, 1'b0, unused);          // Pop edge, back to idle
    endtask

    task automatic read_and_check(input string name, input logic [7:0] expected);
        logic [7:0] data;
        jtag_read_byte(data);
        check_value(name, {24'h0, expected}, {24'h0, data});
    endtask

    // ======================== Directed tests ========================
    task automatic test_reset();
        check_value("reset instr_ready", 32'd1, {31'd0, instr_ready});
        check_value("reset a0", 32'd0, a0);
        jtag_reset();
        jtag_load_ir(`JTAG_USER1);
        read_and_check("reset empty read", 8'h00);
    endtask

    task automatic test_addi();
        int          imms [8];
        logic [31:0] sum;
        imms = '{-2048, 2047, 5, -37, 100, -2048, -1, 1000};
        sum  = 32'd0;
        for (int i = 0; i < 8; i++) begin
            send_instr(enc_addi(5'd10, 5'd10, imms[i][11:0]));
            sum = sum + imms[i];                // 32-bit wraparound model
            check_value("addi running sum", sum, a0);
        end
        send_instr(enc_addi(5'd0, 5'd10, 12'd77));  // Write to x0 is dropped
        send_instr(enc_addi(5'd10, 5'd0, 12'd9));
        check_value("addi x0 zero", 32'd9, a0);
    endtask

    task automatic test_uart_stores();
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = $random(seed);
        b1 = $random(seed);
        send_instr(enc_addi(5'd5, 5'd0, 12'h800));  // Base 0xfffff800, bit 31 set
        send_instr(enc_addi(5'd6, 5'd0, {4'h0, b0}));
        send_instr(enc_addi(5'd7, 5'd0, {4'h0, b1}));
        send_instr(enc_sw(5'd6, 5'd5, 12'd4));       // Positive offset
        send_instr(enc_sw(5'd7, 5'd5, 12'hff8));     // Offset -8
        read_and_check("uart store first", b0);
        read_and_check("uart store second", b1);
        read_and_check("uart store drained", 8'h00);
    endtask

    task automatic test_ignored_store();
        send_instr(enc_addi(5'd8, 5'd0, 12'h100));  // Address bit 31 clear
        send_instr(enc_sw(5'd6, 5'd8, 12'd0));
        read_and_check("ignored store", 8'h00);
    endtask

    task automatic test_back_pressure();
        logic [7:0] bytes [NUM_BP];
        for (int i = 0; i < NUM_BP; i++) begin
            bytes[i] = $random(seed);
            send_instr(enc_addi(5'(11 + i), 5'd0, {4'h0, bytes[i]}));
        end
        for (int i = 0; i < `JTAG_FIFO_DEPTH; i++) begin
            send_instr(enc_sw(5'(11 + i), 5'd5, 12'd0));  // Spend every credit
        end
        @(negedge tck);
        instr       = enc_sw(5'(11 + `JTAG_FIFO_DEPTH), 5'd5, 12'd0);
        instr_valid = 1'b1;
        for (int c = 0; c < HOLD_CYCLES; c++) begin
            check_value("back pressure ready low", 32'd0, {31'd0, instr_ready});
            @(negedge tck);
        end
        instr_valid = 1'b0;
        read_and_check("back pressure first byte", bytes[0]);
        send_instr(enc_sw(5'(11 + `JTAG_FIFO_DEPTH), 5'd5, 12'd0));  // Needs returned credit
        for (int i = 1; i < NUM_BP; i++) begin
            read_and_check("back pressure order", bytes[i]);
        end
    endtask

    // ======================== Main sequence ========================
    initial begin
        seed        = 32'hd878a056;
        reset_n     = 1'b0;
        tms         = 1'b1;
        tdi         = 1'b0;
        instr       = 32'd0;
        instr_valid = 1'b0;
        repeat (5) @(posedge tck);
        @(negedge tck);
        reset_n = 1'b1;

        test_reset();
        test_addi();
        test_uart_stores();
        test_ignored_store();
        test_back_pressure();

        if (jtag_uart_top_inst.jtag_uart_checker_inst.assert_fails == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "assertion failures");
        end
    end

endmodule
